//--- logic/mem_pkg.sv
package mem_pkg;

  // Word address and data word on the memory bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Beats in a read minus one, so 1 to 4 beats
  typedef logic [1:0] burst_len_t;

  // Arbitration policy
  typedef enum logic {
    arb_fixed,       // Client 0 always wins a tie
    arb_round_robin  // Loser of the last grant wins a tie
  } arb_mode_t;

  // Configuration register index
  typedef logic [1:0] cfg_addr_t;

  localparam cfg_addr_t cfg_mode_reg   = 2'd0;
  localparam cfg_addr_t cfg_count0_reg = 2'd1;
  localparam cfg_addr_t cfg_count1_reg = 2'd2;

  // Grant counter
  typedef logic [15:0] count_t;

endpackage

//--- logic/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

  mem_pkg::addr_t      addr;
  mem_pkg::burst_len_t burst_len;
  logic                rd;
  logic                wr;
  mem_pkg::data_t      wr_data;
  mem_pkg::data_t      rd_data;
  logic                rd_valid;
  logic                waitrequest;

  modport master (
    output addr, burst_len, rd, wr, wr_data,
    input  rd_data, rd_valid, waitrequest
  );

  modport slave (
    input  addr, burst_len, rd, wr, wr_data,
    output rd_data, rd_valid, waitrequest
  );

endinterface

//--- logic/arb_config.sv
`timescale 1ns/1ps

module arb_config (
  input  logic                clock,
  input  logic                rst,
  input  logic                cfg_wr,
  input  mem_pkg::cfg_addr_t  cfg_addr,
  input  mem_pkg::data_t      cfg_wr_data,
  output mem_pkg::data_t      cfg_rd_data,
  input  logic                grant0,
  input  logic                grant1,
  output mem_pkg::arb_mode_t  mode
);

  mem_pkg::count_t count0;
  mem_pkg::count_t count1;

  always_ff @(posedge clock) begin
    if (rst) begin
      mode   <= mem_pkg::arb_fixed;
      count0 <= '0;
      count1 <= '0;
    end else begin
      if (cfg_wr && cfg_addr == mem_pkg::cfg_mode_reg) begin
        mode <= mem_pkg::arb_mode_t'(cfg_wr_data[0]);
      end
      // Counters stick at full scale
      if (grant0 && count0 != '1) count0 <= count0 + 1'b1;
      if (grant1 && count1 != '1) count1 <= count1 + 1'b1;
    end
  end

  always_comb begin
    case (cfg_addr)
      mem_pkg::cfg_mode_reg:   cfg_rd_data = mem_pkg::data_t'(mode);
      mem_pkg::cfg_count0_reg: cfg_rd_data = mem_pkg::data_t'(count0);
      mem_pkg::cfg_count1_reg: cfg_rd_data = mem_pkg::data_t'(count1);
      default:                 cfg_rd_data = '0; // Unused index
    endcase
  end

endmodule

//--- logic/mem_arb.sv
`timescale 1ns/1ps

module mem_arb (
  input  logic                 clock,
  input  logic                 rst,
  input  mem_pkg::arb_mode_t   mode,

  input  mem_pkg::addr_t       c0_addr,
  input  mem_pkg::burst_len_t  c0_burst_len,
  input  logic                 c0_rd,
  input  logic                 c0_wr,
  input  mem_pkg::data_t       c0_wr_data,
  output mem_pkg::data_t       c0_rd_data,
  output logic                 c0_rd_valid,
  output logic                 c0_waitrequest,

  input  mem_pkg::addr_t       c1_addr,
  input  mem_pkg::burst_len_t  c1_burst_len,
  input  logic                 c1_rd,
  input  logic                 c1_wr,
  input  mem_pkg::data_t       c1_wr_data,
  output mem_pkg::data_t       c1_rd_data,
  output logic                 c1_rd_valid,
  output logic                 c1_waitrequest,

  mem_bus_if.master            m,

  output logic                 grant0,
  output logic                 grant1
);

  typedef enum logic {
    idle,
    read_burst
  } state_t;

  state_t              state;
  logic                lock_client;  // Owner of the read burst
  mem_pkg::burst_len_t lock_len;
  mem_pkg::burst_len_t beat_cnt;
  logic                last_winner;

  logic req0;
  logic req1;
  logic pick;
  logic accept;

  assign req0 = c0_rd | c0_wr;
  assign req1 = c1_rd | c1_wr;

  always_comb begin
    if (req0 && req1) begin
      if (mode == mem_pkg::arb_round_robin) pick = ~last_winner;
      else pick = 1'b0;
    end else begin
      pick = req1;
    end
  end

  // Winner goes straight through while idle
  assign m.addr      = pick ? c1_addr      : c0_addr;
  assign m.burst_len = pick ? c1_burst_len : c0_burst_len;
  assign m.wr_data   = pick ? c1_wr_data   : c0_wr_data;
  assign m.rd        = (state == idle) && (pick ? c1_rd : c0_rd);
  assign m.wr        = (state == idle) && (pick ? c1_wr : c0_wr);

  assign c0_waitrequest = (state != idle) || pick || m.waitrequest;
  assign c1_waitrequest = (state != idle) || !pick || m.waitrequest;

  assign accept = (m.rd || m.wr) && !m.waitrequest;
  assign grant0 = accept && !pick;
  assign grant1 = accept && pick;

  // Read returns only reach the lock owner
  assign c0_rd_valid = m.rd_valid && (state == read_burst) && !lock_client;
  assign c1_rd_valid = m.rd_valid && (state == read_burst) && lock_client;
  assign c0_rd_data  = c0_rd_valid ? m.rd_data : '0;
  assign c1_rd_data  = c1_rd_valid ? m.rd_data : '0;

  always_ff @(posedge clock) begin
    if (rst) begin
      state       <= idle;
      lock_client <= 1'b0;
      lock_len    <= '0;
      beat_cnt    <= '0;
      last_winner <= 1'b1;  // Client 0 takes the first tie
    end else begin
      case (state)
        idle: begin
          if (accept) begin
            last_winner <= pick;
            if (m.rd) begin
              state       <= read_burst;
              lock_client <= pick;
              lock_len    <= m.burst_len;
              beat_cnt    <= '0;
            end
          end
        end
        read_burst: begin
          if (m.rd_valid) begin
            if (beat_cnt == lock_len) state <= idle;
            else beat_cnt <= beat_cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

//--- logic/burst_memory.sv
`timescale 1ns/1ps

module burst_memory #(
  parameter int DEPTH        = 1024,
  parameter int READ_LATENCY = 2
) (
  input  logic      clock,
  input  logic      rst,
  mem_bus_if.slave  s
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int DW = $clog2(READ_LATENCY + 1);

  mem_pkg::data_t mem [DEPTH];

  logic                busy;       // Read outstanding
  logic                last_sent;
  logic [DW-1:0]       delay_cnt;
  mem_pkg::burst_len_t beats_left;
  mem_pkg::addr_t      rd_ptr;
  logic                rd_start;
  logic                beat_issue;

  function automatic logic [AW-1:0] mem_index(input mem_pkg::addr_t a);
    return AW'(a % DEPTH);
  endfunction

  assign s.waitrequest = busy;
  assign rd_start      = s.rd && !busy;
  assign beat_issue    = busy && (delay_cnt == '0) && !last_sent;

  always_ff @(posedge clock) begin
    if (rst) begin
      busy       <= 1'b0;
      last_sent  <= 1'b0;
      delay_cnt  <= '0;
      beats_left <= '0;
      s.rd_valid <= 1'b0;
    end else begin
      s.rd_valid <= beat_issue;
      if (rd_start) begin
        busy       <= 1'b1;
        delay_cnt  <= DW'(READ_LATENCY - 1);
        beats_left <= s.burst_len;
      end else if (busy) begin
        if (delay_cnt != '0) begin
          delay_cnt <= delay_cnt - 1'b1;
        end else if (!last_sent) begin
          if (beats_left == '0) last_sent <= 1'b1;
          else beats_left <= beats_left - 1'b1;
        end else begin
          busy      <= 1'b0;  // Last beat is on the bus now
          last_sent <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (s.wr && !busy) mem[mem_index(s.addr)] <= s.wr_data;
    if (rd_start) begin
      rd_ptr <= s.addr;
    end else if (beat_issue) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
    if (beat_issue) s.rd_data <= mem[mem_index(rd_ptr)];
  end

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
  parameter int DEPTH        = 1024,
  parameter int READ_LATENCY = 2
) (
  input  logic                 clock,
  input  logic                 rst,

  input  mem_pkg::addr_t       c0_addr,
  input  mem_pkg::burst_len_t  c0_burst_len,
  input  logic                 c0_rd,
  input  logic                 c0_wr,
  input  mem_pkg::data_t       c0_wr_data,
  output mem_pkg::data_t       c0_rd_data,
  output logic                 c0_rd_valid,
  output logic                 c0_waitrequest,

  input  mem_pkg::addr_t       c1_addr,
  input  mem_pkg::burst_len_t  c1_burst_len,
  input  logic                 c1_rd,
  input  logic                 c1_wr,
  input  mem_pkg::data_t       c1_wr_data,
  output mem_pkg::data_t       c1_rd_data,
  output logic                 c1_rd_valid,
  output logic                 c1_waitrequest,

  input  logic                 cfg_wr,
  input  mem_pkg::cfg_addr_t   cfg_addr,
  input  mem_pkg::data_t       cfg_wr_data,
  output mem_pkg::data_t       cfg_rd_data
);

  mem_pkg::arb_mode_t mode;
  logic               grant0;
  logic               grant1;

  mem_bus_if m_bus ();

  mem_arb arb (
    .clock          (clock),
    .rst            (rst),
    .mode           (mode),
    .c0_addr        (c0_addr),
    .c0_burst_len   (c0_burst_len),
    .c0_rd          (c0_rd),
    .c0_wr          (c0_wr),
    .c0_wr_data     (c0_wr_data),
    .c0_rd_data     (c0_rd_data),
    .c0_rd_valid    (c0_rd_valid),
    .c0_waitrequest (c0_waitrequest),
    .c1_addr        (c1_addr),
    .c1_burst_len   (c1_burst_len),
    .c1_rd          (c1_rd),
    .c1_wr          (c1_wr),
    .c1_wr_data     (c1_wr_data),
    .c1_rd_data     (c1_rd_data),
    .c1_rd_valid    (c1_rd_valid),
    .c1_waitrequest (c1_waitrequest),
    .m              (m_bus.master),
    .grant0         (grant0),
    .grant1         (grant1)
  );

  arb_config config_regs (
    .clock       (clock),
    .rst         (rst),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wr_data (cfg_wr_data),
    .cfg_rd_data (cfg_rd_data),
    .grant0      (grant0),
    .grant1      (grant1),
    .mode        (mode)
  );

  burst_memory #(
    .DEPTH        (DEPTH),
    .READ_LATENCY (READ_LATENCY)
  ) main_mem (
    .clock (clock),
    .rst   (rst),
    .s     (m_bus.slave)
  );

endmodule

//--- bench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

  localparam int mem_depth       = 1024;
  localparam int read_latency    = 2;
  localparam int test_cycles     = 10 + 80 + 70 + 40 + 80 + 10;
  localparam int watchdog_cycles = test_cycles + 400;  // Generous slack

  logic                clock = 1'b0;
  logic                rst;
  mem_pkg::addr_t      addr [2];
  mem_pkg::burst_len_t burst_len [2];
  mem_pkg::data_t      wr_data [2];
  mem_pkg::data_t      rd_data [2];
  logic [1:0]          rd;
  logic [1:0]          wr;
  logic [1:0]          rd_valid;
  logic [1:0]          waitreq;
  logic                cfg_wr;
  mem_pkg::cfg_addr_t  cfg_addr;
  mem_pkg::data_t      cfg_wr_data;
  mem_pkg::data_t      cfg_rd_data;

  mem_pkg::data_t ref_mem [int];  // Expected memory contents
  logic           beat_owner [$];
  mem_pkg::data_t beat_data [$];
  int             beat_cycle [$];
  int             accept_cycle [2];
  int             grants [2] = '{0, 0};
  logic           last_accept = 1'b1;
  int             cycle = 0;
  int             seed = 15;
  int             errors = 0;

  mem_subsystem #(.DEPTH(mem_depth), .READ_LATENCY(read_latency)) UUT (
    .clock(clock), .rst(rst),
    .c0_addr(addr[0]), .c0_burst_len(burst_len[0]), .c0_rd(rd[0]), .c0_wr(wr[0]),
    .c0_wr_data(wr_data[0]), .c0_rd_data(rd_data[0]), .c0_rd_valid(rd_valid[0]),
    .c0_waitrequest(waitreq[0]),
    .c1_addr(addr[1]), .c1_burst_len(burst_len[1]), .c1_rd(rd[1]), .c1_wr(wr[1]),
    .c1_wr_data(wr_data[1]), .c1_rd_data(rd_data[1]), .c1_rd_valid(rd_valid[1]),
    .c1_waitrequest(waitreq[1]),
    .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wr_data(cfg_wr_data),
    .cfg_rd_data(cfg_rd_data)
  );

  always #5 clock = ~clock;
  always @(posedge clock) cycle <= cycle + 1;

  task automatic log_beat(input logic c);
    if (rd_valid[c]) begin
      beat_owner.push_back(c);
      beat_data.push_back(rd_data[c]);
      beat_cycle.push_back(cycle);
    end
  endtask

  // Return beats sampled mid-cycle
  always @(negedge clock) begin
    log_beat(1'b0);
    log_beat(1'b1);
  end

  task automatic report_mismatch(input string name, input mem_pkg::data_t got,
                                 input mem_pkg::data_t exp);
    $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  function automatic int ref_index(input mem_pkg::addr_t a);
    return int'(a % mem_depth);
  endfunction

  function automatic int count_beats(input logic c);
    int n;
    n = 0;
    foreach (beat_owner[i])
      if (beat_owner[i] == c) n++;
    return n;
  endfunction

  task automatic clear_beats;
    beat_owner.delete();
    beat_data.delete();
    beat_cycle.delete();
  endtask

  // Hold the request until the edge that accepts it
  task automatic client_request(input logic c, input logic is_rd, input mem_pkg::addr_t a,
                                input int len, input mem_pkg::data_t d);
    logic done;
    done = 1'b0;
    addr[c] = a;
    burst_len[c] = mem_pkg::burst_len_t'(len);
    wr_data[c] = d;
    rd[c] = is_rd;
    wr[c] = !is_rd;
    while (!done) begin
      @(negedge clock);
      if (!waitreq[c]) begin
        done = 1'b1;
        accept_cycle[c] = cycle;
      end
      @(posedge clock);
      #1;
    end
    rd[c] = 1'b0;
    wr[c] = 1'b0;
    grants[c]++;
    last_accept = c;
  endtask

  task automatic write_word(input logic c, input mem_pkg::addr_t a, input mem_pkg::data_t d);
    client_request(c, 1'b0, a, 0, d);
    ref_mem[ref_index(a)] = d;
  endtask

  task automatic wait_for_beats(input logic c, input int n);
    while (count_beats(c) < n) begin
      @(posedge clock);
      #1;
    end
    repeat (3) @(posedge clock);  // Window for stray extra beats
    #1;
  endtask

  // A negative first_accept skips the latency check
  task automatic check_beats(input logic c, input mem_pkg::addr_t a, input int n_beats,
                             input int first_accept);
    int k;
    k = 0;
    foreach (beat_owner[i]) begin
      if (beat_owner[i] == c) begin
        if (first_accept >= 0 && beat_cycle[i] != first_accept + read_latency + 1 + k)
          report_mismatch($sformatf("c%0d_rd_valid delay", c),
                          mem_pkg::data_t'(beat_cycle[i] - first_accept),
                          mem_pkg::data_t'(read_latency + 1 + k));
        if (beat_data[i] !== ref_mem[ref_index(a + k)])
          report_mismatch($sformatf("c%0d_rd_data", c), beat_data[i], ref_mem[ref_index(a + k)]);
        k++;
      end
    end
    if (k != n_beats) begin
      $display("Error at %0t: client %0d returned %0d beats, not %0d", $time, c, k, n_beats);
      errors++;
    end
  endtask

  task automatic read_and_check(input logic c, input mem_pkg::addr_t a, input int len);
    clear_beats();
    client_request(c, 1'b1, a, len, '0);
    wait_for_beats(c, len + 1);
    check_beats(c, a, len + 1, accept_cycle[c]);
  endtask

  task automatic read_cfg(input mem_pkg::cfg_addr_t idx, output mem_pkg::data_t v);
    cfg_addr = idx;
    @(negedge clock);
    v = cfg_rd_data;
    @(posedge clock);
    #1;
  endtask

  task automatic write_cfg(input mem_pkg::cfg_addr_t idx, input mem_pkg::data_t d);
    cfg_addr = idx;
    cfg_wr_data = d;
    cfg_wr = 1'b1;
    @(posedge clock);
    #1;
    cfg_wr = 1'b0;
  endtask

  task automatic test_reset_state;
    int e;
    mem_pkg::data_t v;
    e = errors;
    for (int i = 0; i < 4; i++) begin
      read_cfg(mem_pkg::cfg_addr_t'(i), v);
      if (v !== '0) report_mismatch($sformatf("cfg_rd_data[%0d]", i), v, '0);
    end
    if (beat_owner.size() != 0) begin
      $display("Error at %0t: rd_valid went high while idle", $time);
      errors++;
    end
    $display("reset_state: %0d checks failed", errors - e);
  endtask

  task automatic test_single_beats;
    mem_pkg::addr_t a [8];
    int e;
    e = errors;
    for (int i = 0; i < 8; i++) begin
      a[i] = mem_pkg::addr_t'($random(seed));
      write_word(i[0], a[i], mem_pkg::data_t'($random(seed)));
    end
    for (int i = 0; i < 8; i++)
      read_and_check(~i[0], a[i], 0);  // Read back on the other client
    $display("single_beats: %0d checks failed", errors - e);
  endtask

  task automatic test_burst_lengths;
    mem_pkg::addr_t base;
    int e;
    e = errors;
    for (int len = 0; len < 4; len++) begin
      base = mem_pkg::addr_t'($random(seed));
      for (int k = 0; k <= len; k++)
        write_word(k[0], base + k, mem_pkg::data_t'($random(seed)));
      read_and_check(len[0], base, len);
    end
    $display("burst_lengths: %0d checks failed", errors - e);
  endtask

  task automatic test_fixed_priority;
    mem_pkg::addr_t a0;
    mem_pkg::addr_t a1;
    int e;
    int last0;
    e = errors;
    last0 = 0;
    a0 = mem_pkg::addr_t'($random(seed));
    a1 = mem_pkg::addr_t'($random(seed));
    for (int k = 0; k < 4; k++) write_word(1'b0, a0 + k, mem_pkg::data_t'($random(seed)));
    for (int k = 0; k < 2; k++) write_word(1'b1, a1 + k, mem_pkg::data_t'($random(seed)));
    clear_beats();
    fork
      client_request(1'b0, 1'b1, a0, 3, '0);
      client_request(1'b1, 1'b1, a1, 1, '0);
    join
    wait_for_beats(1'b0, 4);
    wait_for_beats(1'b1, 2);
    check_beats(1'b0, a0, 4, accept_cycle[0]);
    check_beats(1'b1, a1, 2, accept_cycle[1]);
    foreach (beat_owner[i])
      if (beat_owner[i] == 1'b0) last0 = beat_cycle[i];
    if (accept_cycle[1] <= last0) begin
      $display("Error at %0t: client 1 accepted before the last client 0 beat", $time);
      errors++;
    end
    $display("fixed_priority: %0d checks failed", errors - e);
  endtask

  task automatic test_round_robin;
    mem_pkg::addr_t a0;
    mem_pkg::addr_t a1;
    logic first;
    int e;
    e = errors;
    write_cfg(mem_pkg::cfg_mode_reg, 32'd1);
    a0 = mem_pkg::addr_t'($random(seed));
    a1 = mem_pkg::addr_t'($random(seed));
    for (int k = 0; k < 3; k++) begin
      write_word(1'b0, a0 + k, mem_pkg::data_t'($random(seed)));
      write_word(1'b1, a1 + k, mem_pkg::data_t'($random(seed)));
    end
    first = ~last_accept;  // Loser of the last grant takes the tie
    clear_beats();
    fork
      for (int r = 0; r < 3; r++) client_request(1'b0, 1'b1, a0 + r, 0, '0);
      for (int r = 0; r < 3; r++) client_request(1'b1, 1'b1, a1 + r, 0, '0);
    join
    wait_for_beats(1'b0, 3);
    wait_for_beats(1'b1, 3);
    foreach (beat_owner[i])
      if (beat_owner[i] !== (first ^ i[0]))
        report_mismatch($sformatf("rd_valid owner of beat %0d", i),
                        mem_pkg::data_t'(beat_owner[i]), mem_pkg::data_t'(first ^ i[0]));
    check_beats(1'b0, a0, 3, -1);
    check_beats(1'b1, a1, 3, -1);
    $display("round_robin: %0d checks failed", errors - e);
  endtask

  task automatic test_grant_counts;
    mem_pkg::data_t v;
    int e;
    e = errors;
    read_cfg(mem_pkg::cfg_count0_reg, v);
    if (v !== mem_pkg::data_t'(grants[0]))
      report_mismatch("count0", v, mem_pkg::data_t'(grants[0]));
    read_cfg(mem_pkg::cfg_count1_reg, v);
    if (v !== mem_pkg::data_t'(grants[1]))
      report_mismatch("count1", v, mem_pkg::data_t'(grants[1]));
    $display("grant_counts: %0d checks failed", errors - e);
  endtask

  initial begin
    rst = 1'b1;
    rd = '0;
    wr = '0;
    addr = '{'0, '0};
    burst_len = '{'0, '0};
    wr_data = '{'0, '0};
    cfg_wr = 1'b0;
    cfg_addr = '0;
    cfg_wr_data = '0;
    repeat (4) @(posedge clock);
    #1;
    rst = 1'b0;
    test_reset_state();
    test_single_beats();
    test_burst_lengths();
    test_fixed_priority();
    test_round_robin();
    test_grant_counts();
    $display("Tests run: 6, checks failed: %0d", errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("Error: run still going after %0d cycles", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog.f
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/arb_config.sv
logic/mem_arb.sv
logic/burst_memory.sv
logic/mem_subsystem.sv
bench/tb_mem_subsystem.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_mem_subsystem
RTL_TOP    ?= mem_subsystem
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
